// ==== build.f ====
+incdir+.
core_pkg.sv
apb_host_port.sv
instr_decode.sv
alu_execute.sv
result_writeback.sv
alu_core_top.sv
tb_alu_core.sv

// ==== Bender.yml ====
package:
  name: alu_core

sources:
  - include_dirs:
      - .
    files:
      - core_pkg.sv
      - apb_host_port.sv
      - instr_decode.sv
      - alu_execute.sv
      - result_writeback.sv
      - alu_core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_alu_core.sv

// ==== tb_alu_core.sv ====
// Testbench for the integer execution core
// Feeds RV32I words and register reads over APB, keeps a model of the
// register file and the issued counter, and checks every access phase
// with concurrent assertions

`include "core_settings.svh"

module tb_alu_core;

    localparam int        RANDOM_COUNT   = 200;
    localparam int        TRANSFER_COUNT = 380;
    localparam int        CLK_PERIOD     = 4;
    localparam int        WATCHDOG_TIME  = TRANSFER_COUNT * 3 * CLK_PERIOD + 200;
    localparam bit [31:0] RANDOM_SEED    = 32'h878a;

    logic                clk;
    logic                rst_n;
    logic                psel;
    logic                penable;
    logic                pwrite;
    core_pkg::apb_addr_t paddr;
    core_pkg::word_t     pwdata;
    logic                pready;
    core_pkg::word_t     prdata;
    logic                pslverr;

    // Expected response of the transfer on the bus
    logic            exp_err;
    core_pkg::word_t exp_rdata;

    core_pkg::word_t model_regs [0:31];
    core_pkg::word_t model_count;
    integer          seed;
    int              error_count;
    int              pass_count;
    int              fail_count;
    int              errors_at_start;

    alu_core_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Response checks
    ap_pready: assert property (
        @(posedge clk) disable iff (!rst_n) (psel && penable) |-> pready
    ) else begin
        error_count++;
        $display("** Error: pready at %h expected %h got %h",
                 $sampled(paddr), 1'b1, $sampled(pready));
    end

    ap_pslverr: assert property (
        @(posedge clk) disable iff (!rst_n) (psel && penable) |-> (pslverr == exp_err)
    ) else begin
        error_count++;
        $display("** Error: pslverr at %h expected %h got %h",
                 $sampled(paddr), $sampled(exp_err), $sampled(pslverr));
    end

    ap_err_idle: assert property (
        @(posedge clk) disable iff (!rst_n) !(psel && penable) |-> !pslverr
    ) else begin
        error_count++;
        $display("** Error: pslverr outside an access phase expected %h got %h",
                 1'b0, $sampled(pslverr));
    end

    ap_prdata: assert property (
        @(posedge clk) disable iff (!rst_n)
        (psel && penable && !pwrite && !exp_err) |-> (prdata == exp_rdata)
    ) else begin
        error_count++;
        $display("** Error: prdata at %h expected %h got %h",
                 $sampled(paddr), $sampled(exp_rdata), $sampled(prdata));
    end

    ////////////////////////////////////////
    // Instruction encoding
    function automatic core_pkg::word_t r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                                    input logic [4:0] rd, input logic [4:0] rs1,
                                                    input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic core_pkg::word_t i_type_word(input logic [11:0] imm, input logic [2:0] f3,
                                                    input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic core_pkg::word_t lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // RV32I semantics on the model registers
    function automatic core_pkg::word_t model_result(input core_pkg::word_t instr);
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t res;
        logic            is_reg_op;
        a         = model_regs[instr[19:15]];
        is_reg_op = (instr[6:0] == 7'b0110011);
        b         = is_reg_op ? model_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
        case (instr[14:12])
            3'd0:    res = (is_reg_op && instr[30]) ? a - b : a + b;
            3'd1:    res = a << b[4:0];
            3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    res = (a < b) ? 32'd1 : 32'd0;
            3'd4:    res = a ^ b;
            3'd5:    res = instr[30] ? core_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
        if (instr[6:0] == 7'b0110111) begin
            res = {instr[31:12], 12'h000};
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // APB driver
    task automatic apb_write(input core_pkg::apb_addr_t addr, input core_pkg::word_t data,
                             input logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        exp_err = err;
        @(negedge clk);
        penable = 1'b1;
    endtask

    task automatic read_check(input core_pkg::apb_addr_t addr, input core_pkg::word_t data,
                              input logic err);
        @(negedge clk);
        psel      = 1'b1;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = addr;
        exp_err   = err;
        exp_rdata = data;
        @(negedge clk);
        penable = 1'b1;
    endtask

    task automatic bus_idle();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        exp_err = 1'b0;
    endtask

    // Write one word to the instruction port and update the model
    task automatic issue(input core_pkg::word_t instr, input logic legal);
        apb_write(`ADDR_INSTR, instr, !legal);
        if (legal) begin
            model_count = model_count + 1;
            if (instr[11:7] != 5'd0) begin
                model_regs[instr[11:7]] = model_result(instr);
            end
        end
    endtask

    task automatic check_all_state();
        read_check(`ADDR_ISSUED, model_count, 1'b0);
        for (int n = 0; n < 32; n++) begin
            read_check(core_pkg::apb_addr_t'(`ADDR_REG_BASE + 4 * n), model_regs[n], 1'b0);
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        bus_idle();
        if (error_count == errors_at_start) begin
            pass_count++;
            $display("test %s done, no errors", name);
        end else begin
            fail_count++;
            $display("test %s done, %0d errors", name, error_count - errors_at_start);
        end
    endtask

    ////////////////////////////////////////
    // Random legal instructions
    task automatic run_random();
        core_pkg::word_t bits;
        core_pkg::word_t extra;
        logic [2:0]      f3;
        logic [11:0]     imm;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            bits  = $random(seed);
            extra = $random(seed);
            f3    = bits[4:2];
            imm   = extra[11:0];
            if (f3 == 3'd1) begin
                imm[11:5] = 7'b0000000;
            end else if (f3 == 3'd5) begin
                imm[11:5] = extra[20] ? 7'b0100000 : 7'b0000000;
            end
            case (bits[1:0])
                2'd0: issue(r_type_word((extra[20] && (f3 == 3'd0 || f3 == 3'd5)) ?
                                        7'b0100000 : 7'b0000000,
                                        f3, bits[9:5], bits[14:10], bits[19:15]), 1'b1);
                2'd3: issue(lui_word(extra[31:12], bits[9:5]), 1'b1);
                default: issue(i_type_word(imm, f3, bits[9:5], bits[14:10]), 1'b1);
            endcase
        end
    endtask

    // Ends the run if the tests stall
    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired before the tests completed");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        exp_err     = 1'b0;
        exp_rdata   = '0;
        model_count = '0;
        seed        = RANDOM_SEED;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        for (int n = 0; n < 32; n++) begin
            model_regs[n] = '0;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        start_test();
        check_all_state();
        end_test("reset_values");

        // Immediate forms with sign and shift edge cases
        start_test();
        issue(lui_word(20'h80000, 5'd1), 1'b1);
        issue(i_type_word(12'hffb, 3'd0, 5'd2, 5'd0), 1'b1);
        issue(i_type_word(12'd100, 3'd0, 5'd3, 5'd2), 1'b1);
        issue(i_type_word(12'h0f0, 3'd7, 5'd4, 5'd2), 1'b1);
        issue(i_type_word(12'h7ff, 3'd6, 5'd5, 5'd0), 1'b1);
        issue(i_type_word(12'hfff, 3'd4, 5'd6, 5'd2), 1'b1);
        issue(i_type_word(12'h000, 3'd2, 5'd7, 5'd2), 1'b1);
        issue(i_type_word(12'h001, 3'd3, 5'd8, 5'd2), 1'b1);
        issue(i_type_word(12'hfff, 3'd3, 5'd9, 5'd0), 1'b1);
        issue(i_type_word(12'h000, 3'd1, 5'd10, 5'd2), 1'b1);
        issue(i_type_word(12'h01f, 3'd1, 5'd11, 5'd5), 1'b1);
        issue(i_type_word(12'h01f, 3'd5, 5'd12, 5'd1), 1'b1);
        issue(i_type_word({7'b0100000, 5'd31}, 3'd5, 5'd13, 5'd1), 1'b1);
        issue(i_type_word({7'b0100000, 5'd0}, 3'd5, 5'd14, 5'd2), 1'b1);
        issue(lui_word(20'h12345, 5'd15), 1'b1);
        issue(i_type_word(12'h678, 3'd0, 5'd15, 5'd15), 1'b1);
        check_all_state();
        end_test("immediates");

        // Back to back dependent chain through forwarding
        start_test();
        issue(r_type_word(7'b0000000, 3'd0, 5'd16, 5'd1, 5'd2), 1'b1);
        issue(r_type_word(7'b0100000, 3'd0, 5'd17, 5'd16, 5'd1), 1'b1);
        issue(r_type_word(7'b0100000, 3'd5, 5'd18, 5'd17, 5'd7), 1'b1);
        issue(r_type_word(7'b0000000, 3'd2, 5'd19, 5'd1, 5'd17), 1'b1);
        issue(r_type_word(7'b0000000, 3'd3, 5'd20, 5'd17, 5'd1), 1'b1);
        issue(r_type_word(7'b0100000, 3'd0, 5'd21, 5'd0, 5'd1), 1'b1);
        issue(r_type_word(7'b0000000, 3'd2, 5'd22, 5'd21, 5'd0), 1'b1);
        issue(r_type_word(7'b0000000, 3'd1, 5'd23, 5'd22, 5'd12), 1'b1);
        issue(r_type_word(7'b0000000, 3'd5, 5'd24, 5'd17, 5'd23), 1'b1);
        issue(r_type_word(7'b0000000, 3'd4, 5'd25, 5'd24, 5'd17), 1'b1);
        issue(r_type_word(7'b0000000, 3'd6, 5'd26, 5'd25, 5'd22), 1'b1);
        issue(r_type_word(7'b0000000, 3'd7, 5'd27, 5'd26, 5'd17), 1'b1);
        check_all_state();
        end_test("forwarding_chain");

        // Bad opcode, bad funct7 on SLLI and on SRL
        start_test();
        issue(32'h0000_0e7f, 1'b0);
        issue(i_type_word({7'b0100000, 5'd3}, 3'd1, 5'd28, 5'd2), 1'b0);
        issue(r_type_word(7'b0000001, 3'd5, 5'd28, 5'd1, 5'd2), 1'b0);
        read_check(core_pkg::apb_addr_t'(`ADDR_REG_BASE + 4 * 28), model_regs[28], 1'b0);
        read_check(`ADDR_ISSUED, model_count, 1'b0);
        end_test("illegal_words");

        start_test();
        issue(i_type_word(12'd123, 3'd0, 5'd0, 5'd2), 1'b1);
        read_check(`ADDR_REG_BASE, 32'h0, 1'b0);
        apb_write(`ADDR_ISSUED, 32'h5555_aaaa, 1'b1);
        apb_write(core_pkg::apb_addr_t'(`ADDR_REG_BASE + 4 * 3), 32'h1234_5678, 1'b1);
        read_check(12'h008, 32'h0, 1'b1);
        apb_write(12'h200, 32'h0000_0013, 1'b1);
        read_check(12'h102, 32'h0, 1'b1);
        read_check(`ADDR_ISSUED, model_count, 1'b0);
        end_test("x0_and_bus_errors");

        start_test();
        run_random();
        check_all_state();
        end_test("random_run");

        $display("tests passed %0d failed %0d, assertion errors %0d",
                 pass_count, fail_count, error_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== alu_core_top.sv ====
// Integer execution core, top level
// APB host port feeding a decode, execute and writeback pipeline
// of RV32I ALU instructions

module alu_core_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  core_pkg::apb_addr_t paddr,
    input  core_pkg::word_t     pwdata,
    output logic                pready,
    output core_pkg::word_t     prdata,
    output logic                pslverr
);

    logic                issue_valid;
    logic                illegal;
    core_pkg::reg_addr_t host_rd_addr;
    core_pkg::word_t     host_rd_data;
    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::word_t     rs1_data;
    core_pkg::word_t     rs2_data;
    logic                dec_valid;
    core_pkg::alu_op_t   dec_op;
    core_pkg::reg_addr_t dec_rd;
    core_pkg::word_t     dec_operand_a;
    core_pkg::word_t     dec_operand_b;
    logic                ex_valid;
    core_pkg::reg_addr_t ex_rd;
    core_pkg::word_t     ex_result;

    ////////////////////////////////////////
    // Host port
    apb_host_port u_apb_host_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .illegal      (illegal),
        .host_rd_data (host_rd_data),
        .pready       (pready),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .issue_valid  (issue_valid),
        .host_rd_addr (host_rd_addr)
    );

    ////////////////////////////////////////
    // Pipeline
    // Instruction word comes straight from the APB write data
    instr_decode u_instr_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .instr         (pwdata),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .illegal       (illegal),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .dec_valid     (dec_valid),
        .dec_op        (dec_op),
        .dec_rd        (dec_rd),
        .dec_operand_a (dec_operand_a),
        .dec_operand_b (dec_operand_b)
    );

    alu_execute u_alu_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .dec_valid     (dec_valid),
        .dec_op        (dec_op),
        .dec_rd        (dec_rd),
        .dec_operand_a (dec_operand_a),
        .dec_operand_b (dec_operand_b),
        .ex_valid      (ex_valid),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result)
    );

    result_writeback u_result_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .host_rd_addr (host_rd_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .host_rd_data (host_rd_data)
    );

endmodule

// ==== result_writeback.sv ====
// Register file with writeback
// x1 to x31 written from the execute stage, x0 hard-wired to zero.
// Three combinational read ports, each bypassing the pending execute
// result in the cycle before it lands in the file

`include "core_settings.svh"

module result_writeback (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ex_valid,
    input  core_pkg::reg_addr_t ex_rd,
    input  core_pkg::word_t     ex_result,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    input  core_pkg::reg_addr_t host_rd_addr,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    output core_pkg::word_t     host_rd_data
);

    core_pkg::word_t regs [1:`REG_COUNT-1];

    // Zero, forwarded result or stored value
    function automatic core_pkg::word_t read_port(input core_pkg::reg_addr_t addr);
        core_pkg::word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (ex_valid && (ex_rd == addr)) begin
            data = ex_result;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    ////////////////////////////////////////
    // Write port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ex_valid && (ex_rd != '0)) begin
            regs[ex_rd] <= ex_result;
        end
    end

    ////////////////////////////////////////
    // Read ports
    always_comb rs1_data     = read_port(rs1_addr);
    always_comb rs2_data     = read_port(rs2_addr);
    always_comb host_rd_data = read_port(host_rd_addr);

    // x0 reads zero on every port, forwarding included
    ap_x0_zero: assert property (
        @(posedge clk) ((rs1_addr != '0) || (rs1_data == '0)) &&
                       ((rs2_addr != '0) || (rs2_data == '0)) &&
                       ((host_rd_addr != '0) || (host_rd_data == '0))
    ) else $error("x0 read back nonzero");

endmodule

// ==== alu_execute.sv ====
// Execute stage
// Integer ALU for the RV32I register and immediate operations.
// Result, destination and valid are registered for writeback

`include "core_settings.svh"

module alu_execute (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                dec_valid,
    input  core_pkg::alu_op_t   dec_op,
    input  core_pkg::reg_addr_t dec_rd,
    input  core_pkg::word_t     dec_operand_a,
    input  core_pkg::word_t     dec_operand_b,
    output logic                ex_valid,
    output core_pkg::reg_addr_t ex_rd,
    output core_pkg::word_t     ex_result
);

    logic [4:0]      shamt;
    core_pkg::word_t result;

    // Shift amount from the low bits of B
    assign shamt = dec_operand_b[4:0];

    ////////////////////////////////////////
    // ALU
    always_comb begin
        case (dec_op)
            `ALU_ADD:  result = dec_operand_a + dec_operand_b;
            `ALU_SUB:  result = dec_operand_a - dec_operand_b;
            `ALU_AND:  result = dec_operand_a & dec_operand_b;
            `ALU_OR:   result = dec_operand_a | dec_operand_b;
            `ALU_XOR:  result = dec_operand_a ^ dec_operand_b;
            `ALU_SLT:  result = {31'b0, $signed(dec_operand_a) < $signed(dec_operand_b)};
            `ALU_SLTU: result = {31'b0, dec_operand_a < dec_operand_b};
            `ALU_SLL:  result = dec_operand_a << shamt;
            `ALU_SRL:  result = dec_operand_a >> shamt;
            `ALU_SRA:  result = $signed(dec_operand_a) >>> shamt;
            default:   result = '0;
        endcase
    end

    ////////////////////////////////////////
    // Stage register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_rd     <= dec_rd;
            ex_result <= result;
        end
    end

    ap_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) ex_valid == $past(dec_valid)
    ) else $error("execute valid out of step with decode");

endmodule

// ==== instr_decode.sv ====
// Decode stage
// Splits the RV32I word, checks it against the supported subset, builds
// the immediate and latches operands for execute. Only legal issues
// load the stage

`include "core_settings.svh"

module instr_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue_valid,
    input  core_pkg::word_t     instr,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    output logic                illegal,
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    output logic                dec_valid,
    output core_pkg::alu_op_t   dec_op,
    output core_pkg::reg_addr_t dec_rd,
    output core_pkg::word_t     dec_operand_a,
    output core_pkg::word_t     dec_operand_b
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              f7_zero;
    logic              f7_alt;
    logic              use_imm;
    logic              is_lui;
    core_pkg::alu_op_t alu_op;
    core_pkg::word_t   imm;

    // Map funct3 to an operation with alt selecting SUB or SRA
    function automatic core_pkg::alu_op_t f3_op(input logic [2:0] f3, input logic alt);
        core_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = alt ? `ALU_SUB : `ALU_ADD;
            3'b001:  op = `ALU_SLL;
            3'b010:  op = `ALU_SLT;
            3'b011:  op = `ALU_SLTU;
            3'b100:  op = `ALU_XOR;
            3'b101:  op = alt ? `ALU_SRA : `ALU_SRL;
            3'b110:  op = `ALU_OR;
            default: op = `ALU_AND;
        endcase
        return op;
    endfunction

    ////////////////////////////////////////
    // Field split
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign f7_zero  = (funct7 == 7'b0000000);
    assign f7_alt   = (funct7 == 7'b0100000);
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    always_comb begin
        alu_op  = `ALU_ADD;
        use_imm = 1'b0;
        is_lui  = 1'b0;
        illegal = 1'b0;
        case (opcode)
            OPC_OP: begin
                // Alternate funct7 only on SUB and SRA
                illegal = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
                alu_op  = f3_op(funct3, f7_alt);
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                if (funct3 == 3'b001) begin
                    illegal = !f7_zero;
                end else if (funct3 == 3'b101) begin
                    illegal = !(f7_zero || f7_alt);
                end
                alu_op = f3_op(funct3, (funct3 == 3'b101) && f7_alt);
            end
            OPC_LUI: begin
                use_imm = 1'b1;
                is_lui  = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    // U-type immediate for LUI and sign-extended I-type otherwise
    assign imm = is_lui ? {instr[31:12], 12'b0} : {{20{instr[31]}}, instr[31:20]};

    ////////////////////////////////////////
    // Stage register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= issue_valid && !illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && !illegal) begin
            dec_op        <= alu_op;
            dec_rd        <= instr[11:7];
            dec_operand_a <= is_lui ? '0 : rs1_data;
            dec_operand_b <= use_imm ? imm : rs2_data;
        end
    end

    // Only supported opcodes and funct7 patterns reach execute
    ap_no_illegal_load: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid |-> $past((opcode == OPC_LUI) ||
                            ((opcode == OPC_OP_IMM) && (funct3[1:0] != 2'b01)) ||
                            (((opcode == OPC_OP) || (opcode == OPC_OP_IMM)) &&
                             ((funct7 & 7'b1011111) == 7'b0000000)))
    ) else $error("decode loaded an unsupported word");

endmodule

// ==== apb_host_port.sv ====
// APB host port
// Decodes the register map, issues instruction writes into the decode
// stage, reports slave errors and keeps the issued-instruction counter.
// Zero wait states, every access completes in its first access cycle

`include "core_settings.svh"

module apb_host_port (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  core_pkg::apb_addr_t paddr,
    input  core_pkg::word_t     pwdata,
    input  logic                illegal,
    input  core_pkg::word_t     host_rd_data,
    output logic                pready,
    output core_pkg::word_t     prdata,
    output logic                pslverr,
    output logic                issue_valid,
    output core_pkg::reg_addr_t host_rd_addr
);

    logic                access;
    logic                hit_instr;
    logic                hit_issued;
    logic                hit_reg;
    core_pkg::apb_addr_t reg_offset;
    core_pkg::word_t     issued_count;

    ////////////////////////////////////////
    // Address decode
    assign access     = psel & penable;
    assign hit_instr  = (paddr == `ADDR_INSTR);
    assign hit_issued = (paddr == `ADDR_ISSUED);
    assign reg_offset = paddr - `ADDR_REG_BASE;

    // Register window, word aligned, one word per register
    assign hit_reg = (paddr >= `ADDR_REG_BASE) &&
                     (reg_offset < core_pkg::apb_addr_t'(4 * `REG_COUNT)) &&
                     (reg_offset[1:0] == 2'b00);

    assign host_rd_addr = core_pkg::reg_addr_t'(reg_offset >> 2);

    ////////////////////////////////////////
    // Response
    assign pready      = access;
    assign issue_valid = access & pwrite & hit_instr;

    // Illegal word, read-only target or unmapped address
    assign pslverr = access & ((pwrite & hit_instr & illegal) |
                               (pwrite & (hit_issued | hit_reg)) |
                               ~(hit_instr | hit_issued | hit_reg));

    always_comb begin
        prdata = '0;
        if (hit_issued) begin
            prdata = issued_count;
        end else if (hit_reg) begin
            prdata = host_rd_data;
        end
    end

    // Legal instructions only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issued_count <= '0;
        end else if (issue_valid && !illegal) begin
            issued_count <= issued_count + 1'b1;
        end
    end

    ap_penable_with_psel: assert property (
        @(posedge clk) disable iff (!rst_n) penable |-> psel
    ) else $error("penable high without psel");

endmodule

// ==== core_pkg.sv ====
// Core types
// Vector types shared by the APB port and the decode, execute and
// writeback stages of the integer execution core

`include "core_settings.svh"

package core_pkg;

    ////////////////////////////////////////
    // Data path

    // Data word, also the instruction word
    typedef logic [`XLEN-1:0] word_t;

    ////////////////////////////////////////
    // Register file

    // Architectural register index, x0 to x31
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;

    ////////////////////////////////////////
    // Host side

    // APB byte address
    typedef logic [`APB_ADDR_WIDTH-1:0] apb_addr_t;

    ////////////////////////////////////////
    // Execute

    // ALU operation, codes in the settings header
    typedef logic [3:0] alu_op_t;

endpackage

// ==== core_settings.svh ====
// Core settings
// Widths, APB register map and ALU operation codes shared by the
// integer execution core
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path and register file
`define XLEN            32
`define REG_COUNT       32

// APB register map
`define APB_ADDR_WIDTH  12
`define ADDR_INSTR      12'h000
`define ADDR_ISSUED     12'h004
`define ADDR_REG_BASE   12'h100

// ALU operation codes
`define ALU_ADD         4'd0
`define ALU_SUB         4'd1
`define ALU_AND         4'd2
`define ALU_OR          4'd3
`define ALU_XOR         4'd4
`define ALU_SLT         4'd5
`define ALU_SLTU        4'd6
`define ALU_SLL         4'd7
`define ALU_SRL         4'd8
`define ALU_SRA         4'd9

`endif
